// File: include/memSettings.svh
`ifndef MEM_SETTINGS_SVH
`define MEM_SETTINGS_SVH

// byte address as seen by both requesters
`define MEM_ADDR_WIDTH 32

// data and instruction word
`define MEM_WORD_WIDTH 32

// RAM holds 2**12 bytes
// address bits above this are ignored by the RAM
`define MEM_RAM_DEPTH_LOG2 12

`endif

// File: list.f
+incdir+include
src/memPkg.sv
src/memReqIf.sv
src/byteRam.sv
src/memArbiter.sv
src/byteSequencer.sv
src/memSubsystem.sv
verif/memSubsystemTb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f list.f \
    --top-module memSubsystemTb --Mdir build -o simv

./build/simv > sim.log
cat sim.log

if grep -q "^all tests passed$" sim.log; then
    echo "simulation PASSED"
else
    echo "simulation FAILED"
    exit 1
fi

// File: src/byteRam.sv
`timescale 1ns/1ps
`default_nettype none
`include "memSettings.svh"

module byteRam (
    input wire                           clk,
    input wire                           i_en,
    input wire                           i_write,
    input wire [`MEM_RAM_DEPTH_LOG2-1:0] i_addr,
    input wire [7:0]                     i_wdata,
    output logic [7:0]                   o_rdata
);

    localparam int ramDepth = 1 << `MEM_RAM_DEPTH_LOG2;

    logic [7:0] mem [ramDepth];

    // read register only moves on an enabled read,
    // so a stalled byte stays on o_rdata
    always_ff @(posedge clk) begin
        if (i_en) begin
            if (i_write) begin
                mem[i_addr] <= i_wdata;
            end else begin
                o_rdata <= mem[i_addr];
            end
        end
    end

endmodule

`default_nettype wire

// File: src/byteSequencer.sv
`timescale 1ns/1ps
`default_nettype none

module byteSequencer (
    input wire               clk,
    input wire               rst,
    input wire               i_ioBufferFull,
    memReqIf.server          opBus,
    output logic             o_ramEn,
    output logic             o_ramWrite,
    output memPkg::addrT     o_ramAddr,
    output memPkg::byteT     o_ramWdata,
    input wire memPkg::byteT i_ramRdata
);
    import memPkg::*;

    typedef enum logic [1:0] {
        ST_IDLE   = 2'd0,
        ST_ACCESS = 2'd1,
        ST_WAIT   = 2'd2,
        ST_RESP   = 2'd3
    } stateT;

    stateT      state;
    memOpT      op;
    logic [1:0] byteIdx;
    logic [1:0] lastIdx;
    logic       readPending;
    logic [1:0] pendLane;
    wordT       assembly;
    logic       advance;
    logic       accept;

    // index of the final byte for a given length
    function automatic logic [1:0] lastIndex(input accessLenT len);
        case (len)
            LEN_BYTE: return 2'd0;
            LEN_HALF: return 2'd1;
            default:  return 2'd3;
        endcase
    endfunction

    // I/O buffer full freezes everything
    assign advance = !i_ioBufferFull;
    assign lastIdx = lastIndex(op.len);

    assign opBus.ready     = (state == ST_IDLE) && advance;
    assign opBus.respValid = (state == ST_RESP) && advance;
    assign opBus.respData  = assembly;
    assign accept          = opBus.valid && opBus.ready;

    // one byte per cycle starting at the lsb
    assign o_ramEn    = (state == ST_ACCESS) && advance;
    assign o_ramWrite = op.write;
    assign o_ramAddr  = op.addr + addrT'(byteIdx);
    assign o_ramWdata = op.wdata[{byteIdx, 3'b000} +: 8];

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= ST_IDLE;
            byteIdx     <= 2'd0;
            readPending <= 1'b0;
        end else if (advance) begin
            // a read issued at this edge returns its byte next cycle
            readPending <= o_ramEn && !op.write;
            case (state)
                ST_IDLE: begin
                    if (accept) begin
                        state   <= ST_ACCESS;
                        byteIdx <= 2'd0;
                    end
                end
                ST_ACCESS: begin
                    if (byteIdx == lastIdx) begin
                        // reads need one more cycle for the last byte
                        state <= op.write ? ST_RESP : ST_WAIT;
                    end else begin
                        byteIdx <= byteIdx + 2'd1;
                    end
                end
                ST_WAIT: begin
                    state <= ST_RESP;
                end
                ST_RESP: begin
                    state <= ST_IDLE;
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            if (accept) begin
                op       <= opBus.payload;
                // cleared here so short loads come back zero-extended
                assembly <= '0;
            end else if (readPending) begin
                assembly[{pendLane, 3'b000} +: 8] <= i_ramRdata;
            end
            pendLane <= byteIdx;
        end
    end

endmodule

`default_nettype wire

// File: src/memArbiter.sv
`timescale 1ns/1ps
`default_nettype none

module memArbiter (
    input wire         clk,
    input wire         rst,
    memReqIf.server    fetchBus,
    memReqIf.server    dataBus,
    memReqIf.requester opBus
);
    import memPkg::*;

    logic grantData;
    logic opAccept;
    // set when the operation in flight came from the data port
    logic ownerData;

    assign grantData = dataBus.valid;
    assign opAccept  = opBus.valid && opBus.ready;

    assign opBus.valid = dataBus.valid || fetchBus.valid;

    // data wins and fetch only sees ready when data is not asking
    assign dataBus.ready  = opBus.ready;
    assign fetchBus.ready = opBus.ready && !dataBus.valid;

    always_comb begin
        if (grantData) begin
            opBus.payload.write = dataBus.payload.write;
            opBus.payload.len   = dataBus.payload.len;
            opBus.payload.addr  = dataBus.payload.addr;
            opBus.payload.wdata = dataBus.payload.wdata;
        end else begin
            // fetch is always a full word read
            opBus.payload.write = 1'b0;
            opBus.payload.len   = LEN_WORD;
            opBus.payload.addr  = fetchBus.payload.addr;
            opBus.payload.wdata = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ownerData <= 1'b0;
        end else if (opAccept) begin
            ownerData <= grantData;
        end
    end

    // response goes back to whoever was granted
    assign dataBus.respValid  = opBus.respValid && ownerData;
    assign fetchBus.respValid = opBus.respValid && !ownerData;
    assign dataBus.respData   = opBus.respData;
    assign fetchBus.respData  = opBus.respData;

endmodule

`default_nettype wire

// File: src/memPkg.sv
`default_nettype none
`include "memSettings.svh"

package memPkg;

    typedef logic [`MEM_ADDR_WIDTH-1:0] addrT;
    typedef logic [`MEM_WORD_WIDTH-1:0] wordT;
    typedef logic [7:0]                 byteT;

    // number of bytes moved per access
    typedef enum logic [1:0] {
        LEN_BYTE = 2'd0,
        LEN_HALF = 2'd1,
        LEN_WORD = 2'd2
    } accessLenT;

    typedef struct packed {
        addrT addr;
    } fetchReqT;

    typedef struct packed {
        logic      write;
        accessLenT len;
        addrT      addr;
        wordT      wdata;
    } dataReqT;

    // operation the sequencer runs
    // a fetch becomes a word read
    typedef struct packed {
        logic      write;
        accessLenT len;
        addrT      addr;
        wordT      wdata;
    } memOpT;

endpackage

`default_nettype wire

// File: src/memReqIf.sv
`timescale 1ns/1ps
`default_nettype none

interface memReqIf #(
    parameter type payloadT = memPkg::wordT
);
    import memPkg::*;

    // request handshake
    logic    valid;
    logic    ready;
    payloadT payload;

    // one-cycle response pulse, always taken
    logic    respValid;
    wordT    respData;

    modport requester (
        output valid,
        output payload,
        input  ready,
        input  respValid,
        input  respData
    );

    modport server (
        input  valid,
        input  payload,
        output ready,
        output respValid,
        output respData
    );

endinterface

`default_nettype wire

// File: src/memSubsystem.sv
`timescale 1ns/1ps
`default_nettype none
`include "memSettings.svh"

module memSubsystem (
    input wire                    clk,
    input wire                    rst,
    input wire                    i_ioBufferFull,

    // instruction fetch port
    input wire                    i_fetchValid,
    output logic                  o_fetchReady,
    input wire memPkg::addrT      i_fetchAddr,
    output logic                  o_fetchRespValid,
    output memPkg::wordT          o_fetchInst,

    // load/store port
    input wire                    i_dataValid,
    output logic                  o_dataReady,
    input wire                    i_dataWrite,
    input wire memPkg::accessLenT i_dataLen,
    input wire memPkg::addrT      i_dataAddr,
    input wire memPkg::wordT      i_dataWdata,
    output logic                  o_dataRespValid,
    output memPkg::wordT          o_dataRdata
);
    import memPkg::*;

    memReqIf #(.payloadT(fetchReqT)) fetchBus ();
    memReqIf #(.payloadT(dataReqT))  dataBus ();
    memReqIf #(.payloadT(memOpT))    opBus ();

    logic ramEn;
    logic ramWrite;
    addrT ramAddr;
    byteT ramWdata;
    byteT ramRdata;

    assign fetchBus.valid   = i_fetchValid;
    assign fetchBus.payload = '{addr: i_fetchAddr};
    assign o_fetchReady     = fetchBus.ready;
    assign o_fetchRespValid = fetchBus.respValid;
    assign o_fetchInst      = fetchBus.respData;

    assign dataBus.valid   = i_dataValid;
    assign dataBus.payload = '{write: i_dataWrite, len: i_dataLen,
                               addr: i_dataAddr, wdata: i_dataWdata};
    assign o_dataReady     = dataBus.ready;
    assign o_dataRespValid = dataBus.respValid;
    assign o_dataRdata     = dataBus.respData;

    memArbiter u_arbiter (
        .clk      (clk),
        .rst      (rst),
        .fetchBus (fetchBus),
        .dataBus  (dataBus),
        .opBus    (opBus)
    );

    byteSequencer u_sequencer (
        .clk            (clk),
        .rst            (rst),
        .i_ioBufferFull (i_ioBufferFull),
        .opBus          (opBus),
        .o_ramEn        (ramEn),
        .o_ramWrite     (ramWrite),
        .o_ramAddr      (ramAddr),
        .o_ramWdata     (ramWdata),
        .i_ramRdata     (ramRdata)
    );

    // only the low address bits reach the RAM
    byteRam u_ram (
        .clk     (clk),
        .i_en    (ramEn),
        .i_write (ramWrite),
        .i_addr  (ramAddr[`MEM_RAM_DEPTH_LOG2-1:0]),
        .i_wdata (ramWdata),
        .o_rdata (ramRdata)
    );

endmodule

`default_nettype wire

// File: verif/memSubsystemTb.sv
`timescale 1ns/1ps
`default_nettype none
`include "memSettings.svh"

module memSubsystemTb;
    import memPkg::*;

    localparam int CLK_PERIOD = 8;
    localparam int NUM_ROWS   = 21;
    localparam int MAX_STALL  = 4;
    localparam int RESP_LIMIT = 40;
    localparam int TIMEOUT_NS = NUM_ROWS * (6 + MAX_STALL + 4) * CLK_PERIOD * 4;

    typedef enum logic [1:0] {
        KIND_STORE = 2'd0,
        KIND_LOAD  = 2'd1,
        KIND_FETCH = 2'd2,
        KIND_PAIR  = 2'd3
    } kindT;

    // useModel picks random store data and takes the expected value from the model
    typedef struct packed {
        kindT      kind;
        accessLenT len;
        addrT      addr;
        wordT      wdata;
        wordT      expected;
        logic [3:0] maxStall;
        logic      useModel;
    } rowT;

    logic      clk = 1'b0;
    logic      rst;
    logic      i_ioBufferFull;
    logic      i_fetchValid;
    logic      o_fetchReady;
    addrT      i_fetchAddr;
    logic      o_fetchRespValid;
    wordT      o_fetchInst;
    logic      i_dataValid;
    logic      o_dataReady;
    logic      i_dataWrite;
    accessLenT i_dataLen;
    addrT      i_dataAddr;
    wordT      i_dataWdata;
    logic      o_dataRespValid;
    wordT      o_dataRdata;

    rowT  rows [NUM_ROWS];
    byteT model [1 << `MEM_RAM_DEPTH_LOG2];
    int   errorCount = 0;
    int   checkTotal = 0;

    always #(CLK_PERIOD / 2) clk = ~clk;

    memSubsystem u_dut (
        .clk              (clk),
        .rst              (rst),
        .i_ioBufferFull   (i_ioBufferFull),
        .i_fetchValid     (i_fetchValid),
        .o_fetchReady     (o_fetchReady),
        .i_fetchAddr      (i_fetchAddr),
        .o_fetchRespValid (o_fetchRespValid),
        .o_fetchInst      (o_fetchInst),
        .i_dataValid      (i_dataValid),
        .o_dataReady      (o_dataReady),
        .i_dataWrite      (i_dataWrite),
        .i_dataLen        (i_dataLen),
        .i_dataAddr       (i_dataAddr),
        .i_dataWdata      (i_dataWdata),
        .o_dataRespValid  (o_dataRespValid),
        .o_dataRdata      (o_dataRdata)
    );

    task automatic checkWord(input string name, input wordT got, input wordT exp);
        checkTotal++;
        if (got !== exp) begin
            errorCount++;
            $display("** Error: %s = 0x%08h, expected 0x%08h", name, got, exp);
        end
    endtask

    task automatic checkFlag(input string name, input logic got, input logic exp);
        checkTotal++;
        if (got !== exp) begin
            errorCount++;
            $display("** Error: %s = 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic checkCount(input string name, input int got, input int exp);
        checkTotal++;
        if (got != exp) begin
            errorCount++;
            $display("** Error: %s = 0x%0h, expected 0x%0h", name, got, exp);
        end
    endtask

    task automatic reportFailure(input string msg);
        errorCount++;
        $display("ERROR at %0t ns: %s", $time, msg);
    endtask

    function automatic int byteCount(input accessLenT len);
        case (len)
            LEN_BYTE: return 1;
            LEN_HALF: return 2;
            default:  return 4;
        endcase
    endfunction

    // cycles from the accepting edge to the response
    function automatic int expectedCycles(input logic write, input accessLenT len);
        return write ? byteCount(len) + 1 : byteCount(len) + 2;
    endfunction

    // little-endian so the lowest address holds the lsb
    task automatic storeModel(input addrT addr, input accessLenT len, input wordT data);
        addrT a;
        for (int i = 0; i < byteCount(len); i++) begin
            a = addr + addrT'(i);
            model[a[`MEM_RAM_DEPTH_LOG2-1:0]] = data[8*i +: 8];
        end
    endtask

    function automatic wordT modelRead(input addrT addr, input accessLenT len);
        wordT w;
        addrT a;
        w = '0;
        for (int i = 0; i < byteCount(len); i++) begin
            a = addr + addrT'(i);
            w[8*i +: 8] = model[a[`MEM_RAM_DEPTH_LOG2-1:0]];
        end
        return w;
    endfunction

    task automatic driveData(input logic write, input accessLenT len, input addrT addr,
                             input wordT wdata);
        i_dataValid = 1'b1;
        i_dataWrite = write;
        i_dataLen   = len;
        i_dataAddr  = addr;
        i_dataWdata = wdata;
    endtask

    task automatic driveFetch(input addrT addr);
        i_fetchValid = 1'b1;
        i_fetchAddr  = addr;
    endtask

    // returns 1 ns after the accepting edge with the valid dropped
    task automatic waitAccept(input logic isData);
        @(negedge clk);
        while (!(isData ? (i_dataValid && o_dataReady) : (i_fetchValid && o_fetchReady)))
            @(negedge clk);
        if (isData && i_fetchValid)
            checkFlag("o_fetchReady", o_fetchReady, 1'b0);
        @(posedge clk);
        #1;
        if (isData)
            i_dataValid = 1'b0;
        else
            i_fetchValid = 1'b0;
    endtask

    task automatic waitResp(input logic isData, input int stall, output int cycles,
                            output wordT data);
        int   stallLeft;
        logic mine;
        logic other;
        logic done;
        stallLeft = stall;
        cycles    = 0;
        data      = '0;
        done      = 1'b0;
        while (!done) begin
            cycles++;
            // first byte is already issued when the stall starts
            i_ioBufferFull = (cycles > 1) && (stallLeft > 0);
            if (i_ioBufferFull)
                stallLeft--;
            @(negedge clk);
            mine  = isData ? o_dataRespValid : o_fetchRespValid;
            other = isData ? o_fetchRespValid : o_dataRespValid;
            if (other)
                reportFailure("response valid arrived on the wrong port");
            if (isData && i_fetchValid)
                checkFlag("o_fetchReady", o_fetchReady, 1'b0);
            if (mine && i_ioBufferFull)
                reportFailure("response valid high while the I/O buffer is full");
            if (mine) begin
                data = isData ? o_dataRdata : o_fetchInst;
                done = 1'b1;
            end else if (cycles >= RESP_LIMIT) begin
                reportFailure("response never arrived");
                done = 1'b1;
            end
            @(posedge clk);
            #1;
        end
    endtask

    task automatic runRow(input rowT row);
        wordT wdata;
        wordT expected;
        wordT got;
        int   stall;
        int   cycles;
        if (row.kind == KIND_STORE && row.useModel)
            wdata = $urandom();
        else
            wdata = row.wdata;
        stall = (row.maxStall == 0) ? 0 : 1 + int'($urandom() % 32'(row.maxStall));
        case (row.kind)
            KIND_STORE: begin
                driveData(1'b1, row.len, row.addr, wdata);
                waitAccept(1'b1);
                storeModel(row.addr, row.len, wdata);
                waitResp(1'b1, stall, cycles, got);
                checkCount("o_dataRespValid cycles", cycles,
                           expectedCycles(1'b1, row.len) + stall);
            end
            KIND_LOAD, KIND_PAIR: begin
                expected = row.useModel ? modelRead(row.addr, row.len) : row.expected;
                driveData(1'b0, row.len, row.addr, '0);
                // data is presented with the fetch, so it must win
                if (row.kind == KIND_PAIR)
                    driveFetch(row.addr);
                waitAccept(1'b1);
                waitResp(1'b1, stall, cycles, got);
                checkCount("o_dataRespValid cycles", cycles,
                           expectedCycles(1'b0, row.len) + stall);
                checkWord("o_dataRdata", got, expected);
                if (row.kind == KIND_PAIR) begin
                    waitAccept(1'b0);
                    waitResp(1'b0, 0, cycles, got);
                    checkCount("o_fetchRespValid cycles", cycles,
                               expectedCycles(1'b0, LEN_WORD));
                    checkWord("o_fetchInst", got, modelRead(row.addr, LEN_WORD));
                end
            end
            default: begin
                expected = row.useModel ? modelRead(row.addr, LEN_WORD) : row.expected;
                driveFetch(row.addr);
                waitAccept(1'b0);
                waitResp(1'b0, stall, cycles, got);
                checkCount("o_fetchRespValid cycles", cycles,
                           expectedCycles(1'b0, LEN_WORD) + stall);
                checkWord("o_fetchInst", got, expected);
            end
        endcase
    endtask

    task automatic fillTable();
        rows[0]  = '{KIND_STORE, LEN_WORD, 32'h0000_0100, 32'h1122_3344, 32'h0, 4'd0, 1'b0};
        rows[1]  = '{KIND_STORE, LEN_WORD, 32'h0000_0104, 32'hcafe_f00d, 32'h0, 4'd0, 1'b0};
        rows[2]  = '{KIND_LOAD,  LEN_WORD, 32'h0000_0100, 32'h0, 32'h1122_3344, 4'd0, 1'b0};
        rows[3]  = '{KIND_LOAD,  LEN_BYTE, 32'h0000_0100, 32'h0, 32'h0000_0044, 4'd0, 1'b0};
        rows[4]  = '{KIND_LOAD,  LEN_BYTE, 32'h0000_0101, 32'h0, 32'h0000_0033, 4'd0, 1'b0};
        rows[5]  = '{KIND_LOAD,  LEN_BYTE, 32'h0000_0102, 32'h0, 32'h0000_0022, 4'd0, 1'b0};
        rows[6]  = '{KIND_LOAD,  LEN_BYTE, 32'h0000_0103, 32'h0, 32'h0000_0011, 4'd0, 1'b0};
        rows[7]  = '{KIND_LOAD,  LEN_HALF, 32'h0000_0100, 32'h0, 32'h0000_3344, 4'd0, 1'b0};
        rows[8]  = '{KIND_LOAD,  LEN_HALF, 32'h0000_0101, 32'h0, 32'h0000_2233, 4'd0, 1'b0};
        rows[9]  = '{KIND_LOAD,  LEN_HALF, 32'h0000_0102, 32'h0, 32'h0000_1122, 4'd0, 1'b0};
        rows[10] = '{KIND_LOAD,  LEN_HALF, 32'h0000_0103, 32'h0, 32'h0000_0d11, 4'd0, 1'b0};
        rows[11] = '{KIND_STORE, LEN_BYTE, 32'h0000_0102, 32'h0000_00ee, 32'h0, 4'd0, 1'b0};
        rows[12] = '{KIND_LOAD,  LEN_WORD, 32'h0000_0100, 32'h0, 32'h11ee_3344, 4'd0, 1'b0};
        rows[13] = '{KIND_FETCH, LEN_WORD, 32'h0000_0104, 32'h0, 32'hcafe_f00d, 4'd0, 1'b0};
        rows[14] = '{KIND_STORE, LEN_WORD, 32'h0000_0200, 32'h0, 32'h0, 4'd0, 1'b1};
        rows[15] = '{KIND_FETCH, LEN_WORD, 32'h0000_0200, 32'h0, 32'h0, 4'd3, 1'b1};
        rows[16] = '{KIND_LOAD,  LEN_WORD, 32'h0000_0200, 32'h0, 32'h0, 4'd4, 1'b1};
        rows[17] = '{KIND_STORE, LEN_HALF, 32'h0000_0300, 32'h0, 32'h0, 4'd3, 1'b1};
        rows[18] = '{KIND_LOAD,  LEN_HALF, 32'h0000_0300, 32'h0, 32'h0, 4'd2, 1'b1};
        rows[19] = '{KIND_PAIR,  LEN_WORD, 32'h0000_0200, 32'h0, 32'h0, 4'd2, 1'b1};
        // upper address bits do not reach the RAM
        rows[20] = '{KIND_FETCH, LEN_WORD, 32'h8000_0100, 32'h0, 32'h11ee_3344, 4'd0, 1'b0};
    endtask

    initial begin
        void'($urandom(32'h9f661717));
        rst            = 1'b1;
        i_ioBufferFull = 1'b0;
        i_fetchValid   = 1'b0;
        i_fetchAddr    = '0;
        i_dataValid    = 1'b0;
        i_dataWrite    = 1'b0;
        i_dataLen      = LEN_BYTE;
        i_dataAddr     = '0;
        i_dataWdata    = '0;
        fillTable();
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;

        // idle state out of reset
        @(negedge clk);
        checkFlag("o_fetchRespValid", o_fetchRespValid, 1'b0);
        checkFlag("o_dataRespValid", o_dataRespValid, 1'b0);
        checkFlag("o_fetchReady", o_fetchReady, 1'b1);
        checkFlag("o_dataReady", o_dataReady, 1'b1);
        @(posedge clk);
        #1;

        for (int r = 0; r < NUM_ROWS; r++)
            runRow(rows[r]);

        $display("checks: %0d, errors: %0d", checkTotal, errorCount);
        if (errorCount == 0)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("watchdog expired after %0d ns, the run did not finish", TIMEOUT_NS);
        $display("tests failed");
        $finish;
    end

endmodule

`default_nettype wire
